/* pic.f */
pic_pkg.sv
pic_irq_capture.sv
pic_apb_regs.sv
pic_priority.sv
pic_top.sv
tb_pic.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the PIC testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
   --top-module tb_pic \
   -f pic.f \
   --Mdir "$BUILD_DIR" \
   -o sim_pic

"./$BUILD_DIR/sim_pic" | tee "$LOG"

if grep -qx "TB PASSED" "$LOG"; then
   echo "Simulation passed"
else
   echo "Simulation failed, see $LOG"
   exit 1
fi

/* tb_pic.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_pic
   import pic_pkg::*;
();

   localparam int         SYNC_STAGES    = 2;          // Matches DUT default
   localparam logic [4:0] VECTOR_BASE    = 5'b00001;   // Matches DUT default
   localparam int         RESET_CYCLES   = 5;
   localparam int         ROW_MAX_CYCLES = 80;         // Worst case per table row
   localparam int         PRE_CYCLES     = 40;         // Post-reset register checks
   localparam int         MARGIN         = 50;

   // One stimulus row with its name in a parallel queue
   typedef struct packed {
      logic [7:0] imr;
      logic [7:0] irq;           // Zero keeps the lines as they are
      logic [1:0] n_inta;
      logic       eoi_on;
      logic [7:0] eoi_cmd;
      logic [7:0] exp_vec;       // Vector from the last strobe
      logic [7:0] exp_isr;
      logic [7:0] exp_irr;
      logic       exp_int_req;   // Sampled before any strobe
   } row_t;

   logic              ir;
   logic              rst_n;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [ADDR_W-1:0] paddr;
   logic [DATA_W-1:0] pwdata;
   logic [DATA_W-1:0] prdata;
   logic              pready;
   logic              pslverr;
   logic [7:0]        irq;
   logic              int_req;
   logic              inta;
   logic [7:0]        vector;
   logic              vector_valid;

   row_t  rows[$];
   string names[$];
   string cur_name;
   int    cycle_cnt   = 0;
   int    cycle_limit = 0;
   int    seed_val;

   pic_top DUT (
      .ir           (ir),
      .rst_n        (rst_n),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr),
      .irq          (irq),
      .int_req      (int_req),
      .inta         (inta),
      .vector       (vector),
      .vector_valid (vector_valid)
   );

   initial begin
      ir = 1'b0;
      forever #4 ir = ~ir;   // 8 ns period
   end

   // Run length guard
   always @(posedge ir) begin
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
         $display("Timeout: simulation ran past %0d clock cycles", cycle_limit);
         $display("TB FAILED");
         $fatal(1, "cycle limit reached");
      end else begin
         cycle_cnt = cycle_cnt + 1;
      end
   end

   // Vector as the 8259 forms it with the base above the level
   function automatic logic [7:0] vector_for(input logic [2:0] level);
      return {VECTOR_BASE, level};
   endfunction

   function automatic logic [7:0] cmd_byte(input pic_op_e op, input logic [2:0] level);
      return {3'b000, op, level};   // Opcode in bits 4:3
   endfunction

   task automatic check(input string what, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp) begin
         $display("Mismatch %s %s: expected %h, actual %h", cur_name, what, exp, act);
         $display("TB FAILED");
         $fatal(1, "value check failed");
      end
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge ir);
   endtask

   task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [7:0] data,
                            output logic err);
      @(negedge ir);
      psel    = 1'b1;   // Setup
      pwrite  = 1'b1;
      penable = 1'b0;
      paddr   = addr;
      pwdata  = data;
      @(negedge ir);
      penable = 1'b1;   // Access
      @(posedge ir);
      err = pslverr;    // Edge that ends the access
      @(negedge ir);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [7:0] data,
                           output logic err);
      @(negedge ir);
      psel    = 1'b1;
      pwrite  = 1'b0;
      penable = 1'b0;
      paddr   = addr;
      @(negedge ir);
      penable = 1'b1;
      @(posedge ir);
      data = prdata;
      err  = pslverr;
      @(negedge ir);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // One acknowledge strobe and its vector
   task automatic do_inta(output logic [7:0] vec);
      @(negedge ir);
      check("vector_valid before inta", 8'h00, {7'd0, vector_valid});
      inta = 1'b1;
      @(negedge ir);
      inta = 1'b0;
      check("vector_valid after inta", 8'h01, {7'd0, vector_valid});   // Cycle after strobe
      vec = vector;
      @(negedge ir);
      check("vector_valid width", 8'h00, {7'd0, vector_valid});   // Single cycle only
   endtask

   task automatic add_row(input string name, input logic [7:0] imr, input logic [7:0] pat,
                          input logic [1:0] n_inta, input logic eoi_on,
                          input logic [7:0] eoi_cmd, input logic [7:0] exp_vec,
                          input logic [7:0] exp_isr, input logic [7:0] exp_irr,
                          input logic exp_req);
      row_t r;
      r.imr         = imr;
      r.irq         = pat;
      r.n_inta      = n_inta;
      r.eoi_on      = eoi_on;
      r.eoi_cmd     = eoi_cmd;
      r.exp_vec     = exp_vec;
      r.exp_isr     = exp_isr;
      r.exp_irr     = exp_irr;
      r.exp_int_req = exp_req;
      rows.push_back(r);
      names.push_back(name);
   endtask

   task automatic fill_table();
      logic [7:0] ns;
      logic [7:0] none;
      ns   = cmd_byte(OP_NS_EOI, 3'd0);
      none = 8'h00;
      // Single level then NS EOI
      add_row("single_l3", 8'hF7, 8'h08, 2'd1, 1'b0, none, vector_for(3'd3), 8'h08, 8'h00, 1'b1);
      add_row("ns_eoi_l3", 8'hF7, 8'h00, 2'd0, 1'b1, ns, 8'h00, 8'h00, 8'h00, 1'b0);
      // Levels 2, 3 and masked 5 together
      add_row("multi_first", 8'hF3, 8'h2C, 2'd1, 1'b1, ns, vector_for(3'd2), 8'h00, 8'h28, 1'b1);
      add_row("multi_second", 8'hF3, 8'h00, 2'd1, 1'b1, ns, vector_for(3'd3), 8'h00, 8'h20,
              1'b1);
      add_row("masked_idle", 8'hF3, 8'h00, 2'd1, 1'b0, none, vector_for(3'd7), 8'h00, 8'h20,
              1'b0);
      add_row("drain_l5", 8'h00, 8'h00, 2'd1, 1'b1, ns, vector_for(3'd5), 8'h00, 8'h00, 1'b1);
      // Nesting around level 4
      add_row("nest_l4", 8'h00, 8'h10, 2'd1, 1'b0, none, vector_for(3'd4), 8'h10, 8'h00, 1'b1);
      add_row("nest_l6_blocked", 8'h00, 8'h40, 2'd0, 1'b0, none, 8'h00, 8'h10, 8'h40, 1'b0);
      add_row("nest_l1_wins", 8'h00, 8'h02, 2'd1, 1'b0, none, vector_for(3'd1), 8'h12, 8'h40,
              1'b1);
      add_row("spurious_nested", 8'h00, 8'h00, 2'd1, 1'b0, none, vector_for(3'd7), 8'h12,
              8'h40, 1'b0);
      // NS EOI leaves level 4 in service
      add_row("ns_eoi_l1", 8'h00, 8'h00, 2'd0, 1'b1, ns, 8'h00, 8'h10, 8'h40, 1'b0);
      add_row("nest_l2_wins", 8'h00, 8'h04, 2'd1, 1'b0, none, vector_for(3'd2), 8'h14, 8'h40,
              1'b1);
      // Specific EOI hits a lower level than the highest in service
      add_row("sp_eoi_l4", 8'h00, 8'h00, 2'd0, 1'b1, cmd_byte(OP_SP_EOI, 3'd4), 8'h00, 8'h04,
              8'h40, 1'b0);
      add_row("ns_eoi_l2", 8'h00, 8'h00, 2'd0, 1'b1, ns, 8'h00, 8'h00, 8'h40, 1'b0);
      add_row("drain_l6", 8'h00, 8'h00, 2'd1, 1'b1, cmd_byte(OP_SP_EOI, 3'd6),
              vector_for(3'd6), 8'h00, 8'h00, 1'b1);
   endtask

   // Register state straight out of reset
   task automatic check_reset();
      logic [7:0] data;
      logic       err;
      cur_name = "reset";
      @(negedge ir);
      check("int_req", 8'h00, {7'd0, int_req});
      check("vector_valid", 8'h00, {7'd0, vector_valid});
      check("pready", 8'h01, {7'd0, pready});
      apb_read(REG_IMR, data, err);
      check("imr", 8'hFF, data);
      check("pslverr", 8'h00, {7'd0, err});
      apb_read(REG_CMD, data, err);   // Read select starts on IRR
      check("irr", 8'h00, data);
      apb_write(4'h8, 8'h00, err);
      check("pslverr unmapped write", 8'h01, {7'd0, err});
      apb_read(4'h8, data, err);
      check("pslverr unmapped read", 8'h01, {7'd0, err});
      check("unmapped data", 8'h00, data);
      apb_read(REG_IMR, data, err);
      check("imr after unmapped write", 8'hFF, data);
   endtask

   task automatic run_row(input int idx);
      row_t       r;
      logic [7:0] data;
      logic [7:0] vec_seen;
      logic       err;
      int         gap;
      r        = rows[idx];
      cur_name = names[idx];
      vec_seen = 8'h00;
      apb_write(REG_IMR, r.imr, err);
      check("pslverr imr write", 8'h00, {7'd0, err});
      if (r.irq != 8'h00) begin
         @(negedge ir);
         irq = 8'h00;                  // Drop first so every line gets a fresh edge
         wait_cycles(SYNC_STAGES + 3);
         irq = r.irq;
         wait_cycles(SYNC_STAGES + 3);
      end else begin
         wait_cycles(2);
      end
      check("int_req", {7'd0, r.exp_int_req}, {7'd0, int_req});
      repeat (r.n_inta) do_inta(vec_seen);
      if (r.n_inta != 2'd0) begin
         check("vector", r.exp_vec, vec_seen);
      end
      if (r.eoi_on) begin
         apb_write(REG_CMD, r.eoi_cmd, err);
      end
      apb_write(REG_CMD, cmd_byte(OP_READ_ISR, 3'd0), err);
      apb_read(REG_CMD, data, err);
      check("isr", r.exp_isr, data);
      apb_write(REG_CMD, cmd_byte(OP_READ_IRR, 3'd0), err);
      apb_read(REG_CMD, data, err);
      check("irr", r.exp_irr, data);
      apb_read(REG_IMR, data, err);
      check("imr", r.imr, data);
      gap = int'($urandom % 4);        // Idle spacing between rows
      wait_cycles(gap);
   endtask

   initial begin
      rst_n   = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      irq     = 8'h00;
      inta    = 1'b0;
      seed_val = $urandom(32'hb0f93d39);
      fill_table();
      cycle_limit = names.size() * ROW_MAX_CYCLES + RESET_CYCLES + PRE_CYCLES + MARGIN;
      repeat (RESET_CYCLES) @(negedge ir);
      rst_n = 1'b1;
      check_reset();
      foreach (rows[i]) begin
         run_row(i);
      end
      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* pic_top.sv */
`default_nettype none
`timescale 1ns/1ps

module pic_top
   import pic_pkg::*;
#(
   parameter logic [4:0] VECTOR_BASE = 5'b00001,
   parameter int         SYNC_STAGES = 2
) (
   input  logic               ir,
   input  logic               rst_n,
   // APB
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  logic [ADDR_W-1:0]  paddr,
   input  logic [DATA_W-1:0]  pwdata,
   output logic [DATA_W-1:0]  prdata,
   output logic               pready,
   output logic               pslverr,
   // Interrupt side
   input  logic [NUM_IRQ-1:0] irq,
   output logic               int_req,
   input  logic               inta,
   output logic [7:0]         vector,
   output logic               vector_valid
);

   logic [NUM_IRQ-1:0] irr;       // Capture to resolver
   logic [NUM_IRQ-1:0] irr_clr;   // Resolver back to capture
   logic [NUM_IRQ-1:0] imr;
   pic_cmd_t           cmd;       // EOI pulses
   pic_status_t        status;    // IRR and ISR for readback

   // Request capture
   pic_irq_capture #(
      .SYNC_STAGES (SYNC_STAGES)
   ) u_capture (
      .ir      (ir),
      .rst_n   (rst_n),
      .irq     (irq),
      .irr_clr (irr_clr),
      .irr     (irr)
   );

   // APB register block
   pic_apb_regs u_regs (
      .ir      (ir),
      .rst_n   (rst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .status  (status),
      .imr     (imr),
      .cmd     (cmd)
   );

   // Priority resolver and ISR
   pic_priority #(
      .VECTOR_BASE (VECTOR_BASE)
   ) u_priority (
      .ir           (ir),
      .rst_n        (rst_n),
      .irr          (irr),
      .imr          (imr),
      .cmd          (cmd),
      .inta         (inta),
      .int_req      (int_req),
      .irr_clr      (irr_clr),
      .vector       (vector),
      .vector_valid (vector_valid),
      .status       (status)
   );

endmodule

`default_nettype wire

/* pic_priority.sv */
`default_nettype none
`timescale 1ns/1ps

module pic_priority
   import pic_pkg::*;
#(
   parameter logic [4:0] VECTOR_BASE = 5'b00001   // Upper vector bits
) (
   input  logic               ir,
   input  logic               rst_n,
   input  logic [NUM_IRQ-1:0] irr,
   input  logic [NUM_IRQ-1:0] imr,
   input  pic_cmd_t           cmd,
   input  logic               inta,           // Acknowledge strobe
   output logic               int_req,
   output logic [NUM_IRQ-1:0] irr_clr,
   output logic [7:0]         vector,
   output logic               vector_valid,
   output pic_status_t        status
);

   // Spurious acknowledge reports the lowest priority level
   localparam logic [LVL_W-1:0] SPUR_LVL = LVL_W'(NUM_IRQ - 1);

   // Lowest set bit wins, returns {found, level}
   function automatic logic [LVL_W:0] find_first(input logic [NUM_IRQ-1:0] bits);
      logic [LVL_W:0] res;
      res = '0;
      for (int i = NUM_IRQ - 1; i >= 0; i--) begin
         if (bits[i]) begin
            res = {1'b1, LVL_W'(i)};   // Lower index overwrites
         end
      end
      return res;
   endfunction

   logic [NUM_IRQ-1:0] isr_q;       // In-service register
   logic [NUM_IRQ-1:0] irr_clr_q;   // Clear mask in flight
   logic [NUM_IRQ-1:0] pend;        // Eligible requests
   logic [NUM_IRQ-1:0] ack_set;     // ISR bit taken on inta
   logic [NUM_IRQ-1:0] eoi_clr;     // ISR bit dropped by EOI
   logic               pend_any;
   logic               isr_any;
   logic [LVL_W-1:0]   pend_lvl;
   logic [LVL_W-1:0]   isr_lvl;

   // Hide a level already acknowledged while its IRR bit clears
   assign pend = irr & ~imr & ~irr_clr_q;

   assign {pend_any, pend_lvl} = find_first(pend);
   assign {isr_any, isr_lvl}   = find_first(isr_q);

   // Fully nested, must beat every level in service
   assign int_req = pend_any && (!isr_any || (pend_lvl < isr_lvl));

   // Winner moves into service
   always_comb begin
      ack_set = '0;
      if (inta && int_req) begin
         ack_set[pend_lvl] = 1'b1;
      end
   end

   // End of interrupt
   always_comb begin
      eoi_clr = '0;
      if (cmd.valid) begin
         case (cmd.op)
            OP_NS_EOI: if (isr_any) eoi_clr[isr_lvl] = 1'b1;   // Highest in service
            OP_SP_EOI: eoi_clr[cmd.level] = 1'b1;
            default:   eoi_clr = '0;   // Read selects never reach here
         endcase
      end
   end

   always_ff @(posedge ir or negedge rst_n) begin
      if (!rst_n) begin
         isr_q        <= '0;
         irr_clr_q    <= '0;
         vector_valid <= 1'b0;
      end else begin
         isr_q        <= (isr_q & ~eoi_clr) | ack_set;
         irr_clr_q    <= ack_set;   // Pulse, empty on spurious inta
         vector_valid <= inta;
      end
   end

   // Vector captured on every strobe
   always_ff @(posedge ir) begin
      if (inta) begin
         vector <= {VECTOR_BASE, int_req ? pend_lvl : SPUR_LVL};
      end
   end

   assign irr_clr = irr_clr_q;
   assign status  = '{irr: irr, isr: isr_q};

endmodule

`default_nettype wire

/* pic_apb_regs.sv */
`default_nettype none
`timescale 1ns/1ps

module pic_apb_regs
   import pic_pkg::*;
(
   input  logic               ir,
   input  logic               rst_n,
   // APB slave
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  logic [ADDR_W-1:0]  paddr,
   input  logic [DATA_W-1:0]  pwdata,
   output logic [DATA_W-1:0]  prdata,
   output logic               pready,
   output logic               pslverr,
   // Resolver side
   input  pic_status_t        status,
   output logic [NUM_IRQ-1:0] imr,
   output pic_cmd_t           cmd
);

   logic             access;    // APB access phase
   logic             wr_en;
   logic             rd_en;
   logic             mapped;    // Offset hits a register
   logic             imr_wr;
   logic             cmd_wr;
   logic             eoi_wr;    // Command write carrying an EOI
   pic_op_e          wr_op;     // Opcode field of pwdata
   logic [LVL_W-1:0] wr_level;  // Level field of pwdata

   logic [NUM_IRQ-1:0] imr_q;
   pic_rdsel_e         rd_sel_q;
   logic               cmd_valid_q;
   pic_op_e            cmd_op_q;
   logic [LVL_W-1:0]   cmd_level_q;

   // Decode
   assign access   = psel & penable;
   assign wr_en    = access & pwrite;
   assign rd_en    = access & ~pwrite;
   assign mapped   = (paddr == REG_CMD) || (paddr == REG_IMR);
   assign imr_wr   = wr_en && (paddr == REG_IMR);
   assign cmd_wr   = wr_en && (paddr == REG_CMD);
   assign wr_op    = pic_op_e'(pwdata[4:3]);
   assign wr_level = pwdata[LVL_W-1:0];
   assign eoi_wr   = cmd_wr && ((wr_op == OP_NS_EOI) || (wr_op == OP_SP_EOI));

   // Zero wait states, error only on unmapped offsets
   assign pready  = 1'b1;
   assign pslverr = access & ~mapped;

   // Mask register, everything masked out of reset
   always_ff @(posedge ir or negedge rst_n) begin
      if (!rst_n) begin
         imr_q <= '1;
      end else if (imr_wr) begin
         imr_q <= pwdata[NUM_IRQ-1:0];
      end
   end

   // Readback select from the two read commands
   always_ff @(posedge ir or negedge rst_n) begin
      if (!rst_n) begin
         rd_sel_q <= RD_IRR;
      end else if (cmd_wr) begin
         case (wr_op)
            OP_READ_IRR: rd_sel_q <= RD_IRR;
            OP_READ_ISR: rd_sel_q <= RD_ISR;
            default:     rd_sel_q <= rd_sel_q;   // EOI leaves it alone
         endcase
      end
   end

   // EOI strobe, one cycle after the write edge
   always_ff @(posedge ir or negedge rst_n) begin
      if (!rst_n) begin
         cmd_valid_q <= 1'b0;
      end else begin
         cmd_valid_q <= eoi_wr;
      end
   end

   // EOI payload, only meaningful while valid
   always_ff @(posedge ir) begin
      if (eoi_wr) begin
         cmd_op_q    <= wr_op;
         cmd_level_q <= wr_level;
      end
   end

   assign cmd = '{valid: cmd_valid_q, op: cmd_op_q, level: cmd_level_q};
   assign imr = imr_q;

   // Read mux, zero outside reads and on unmapped offsets
   always_comb begin
      prdata = '0;
      if (rd_en) begin
         case (paddr)
            REG_CMD: prdata = (rd_sel_q == RD_ISR) ? status.isr : status.irr;
            REG_IMR: prdata = imr_q;
            default: prdata = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* pic_irq_capture.sv */
`default_nettype none
`timescale 1ns/1ps

module pic_irq_capture
   import pic_pkg::*;
#(
   parameter int SYNC_STAGES = 2   // Synchronizer depth
) (
   input  logic               ir,
   input  logic               rst_n,
   input  logic [NUM_IRQ-1:0] irq,       // Asynchronous request lines
   input  logic [NUM_IRQ-1:0] irr_clr,   // One-cycle clear from resolver
   output logic [NUM_IRQ-1:0] irr
);

   // Synchronizer chain, stage 0 samples the pins
   logic [SYNC_STAGES-1:0][NUM_IRQ-1:0] sync_q;
   logic [NUM_IRQ-1:0] sync_line;   // Last synchronizer stage
   logic [NUM_IRQ-1:0] prev_q;      // Delayed copy for edge detect
   logic [NUM_IRQ-1:0] rise;        // Rising edge this cycle
   logic [NUM_IRQ-1:0] irr_q;

   // Every line gets its own chain, all clocked by ir
   always_ff @(posedge ir or negedge rst_n) begin
      if (!rst_n) begin
         sync_q <= '0;
      end else begin
         sync_q[0] <= irq;
         for (int i = 1; i < SYNC_STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];   // Shift toward output
         end
      end
   end

   assign sync_line = sync_q[SYNC_STAGES-1];

   // Edge detector
   always_ff @(posedge ir or negedge rst_n) begin
      if (!rst_n) begin
         prev_q <= '0;
      end else begin
         prev_q <= sync_line;
      end
   end

   assign rise = sync_line & ~prev_q;

   // Request register, clear first then set so a fresh edge survives
   always_ff @(posedge ir or negedge rst_n) begin
      if (!rst_n) begin
         irr_q <= '0;
      end else begin
         irr_q <= (irr_q & ~irr_clr) | rise;
      end
   end

   assign irr = irr_q;

endmodule

`default_nettype wire

/* pic_pkg.sv */
`default_nettype none

package pic_pkg;

   // Request levels, 8 as on the 8259
   localparam int NUM_IRQ = 8;
   localparam int LVL_W   = 3;   // Level field width

   // APB geometry
   localparam int ADDR_W = 4;
   localparam int DATA_W = 8;

   // Register byte offsets, anything else is unmapped
   localparam logic [ADDR_W-1:0] REG_CMD = 4'h0;
   localparam logic [ADDR_W-1:0] REG_IMR = 4'h4;

   // Command opcode, bits 4:3 of a write to REG_CMD
   typedef enum logic [1:0] {
      OP_NS_EOI   = 2'd0,   // Clear highest ISR bit
      OP_SP_EOI   = 2'd1,   // Clear named ISR bit
      OP_READ_IRR = 2'd2,   // Readback select IRR
      OP_READ_ISR = 2'd3    // Readback select ISR
   } pic_op_e;

   // What REG_CMD returns on a read
   typedef enum logic [0:0] {
      RD_IRR = 1'b0,
      RD_ISR = 1'b1
   } pic_rdsel_e;

   // EOI command, register block to resolver
   typedef struct packed {
      logic             valid;   // One-cycle pulse
      pic_op_e          op;
      logic [LVL_W-1:0] level;   // Used by specific EOI only
   } pic_cmd_t;

   // Readback status, resolver to register block
   typedef struct packed {
      logic [NUM_IRQ-1:0] irr;
      logic [NUM_IRQ-1:0] isr;
   } pic_status_t;

endpackage

`default_nettype wire
